/* Makefile */
VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	cat $(LOG)

check: run
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "FAIL: no pass line in $(LOG)"; exit 1)
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// frame and line timing
`define UART_DATA_W        8    // data bits per frame
`define UART_CLKS_PER_BIT  8    // clocks per serial bit
`define UART_SYNC_STAGES   3    // rx synchroniser depth

// apb register offsets
`define UART_ADDR_TXDATA   4'h0 // write starts a frame
`define UART_ADDR_RXDATA   4'h4 // read clears rx flags
`define UART_ADDR_STATUS   4'h8 // status_t in low bits
`define UART_ADDR_CTRL     4'hC // parity config

`endif

/* list.f */
+incdir+include
src/apb_pkg.sv
src/uart_pkg.sv
src/uart_ctrl.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_top.sv
verification/uart_tb.sv

/* src/apb_pkg.sv */
`include "uart_macros.svh"

package apb_pkg;

    // request from the bus master
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;   // byte offset inside the uart window
        logic [31:0] pwdata;
    } apb_req_t;

    // response back to the master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;  // no wait states
        logic        pslverr; // busy tx refusal
    } apb_rsp_t;

    // write word seen by TXDATA
    typedef struct packed {
        logic [31-`UART_DATA_W:0] rsvd;
        logic [`UART_DATA_W-1:0]  tx_byte; // byte to serialise
    } apb_data_view_t;

    // write word seen by CTRL
    typedef struct packed {
        logic [29:0] rsvd;
        logic        parity_odd; // bit 1
        logic        parity_en;  // bit 0
    } apb_ctrl_view_t;

    // one pwdata word, decoded by address
    typedef union packed {
        apb_data_view_t data;
        apb_ctrl_view_t ctrl;
    } apb_wdata_u;

endpackage

/* src/uart_ctrl.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  apb_pkg::apb_req_t       i_apb,
    output apb_pkg::apb_rsp_t       o_apb,
    output uart_pkg::frame_cfg_t    o_cfg,
    output logic                    o_tx_start,
    output logic [`UART_DATA_W-1:0] o_tx_data,
    input  logic                    i_tx_busy,
    input  logic                    i_rx_done,
    input  uart_pkg::rx_result_t    i_rx_result
);
    import apb_pkg::*;
    import uart_pkg::*;

    apb_wdata_u              wdata;        // pwdata seen through two views
    logic                    access;       // apb access phase
    logic                    wr;
    logic                    rd;
    logic                    wr_tx;        // TXDATA write
    logic                    wr_ctrl;      // CTRL write
    logic                    rd_rx;        // RXDATA read clears the flags
    frame_cfg_t              cfg_q;
    logic [`UART_DATA_W-1:0] rx_data_q;    // last received byte
    logic                    rx_valid_q;
    logic                    parity_err_q;
    logic                    frame_err_q;
    logic                    overrun_q;
    status_t                 status;

    assign wdata   = i_apb.pwdata;
    assign access  = i_apb.psel & i_apb.penable;
    assign wr      = access & i_apb.pwrite;
    assign rd      = access & ~i_apb.pwrite;
    assign wr_tx   = wr & (i_apb.paddr == `UART_ADDR_TXDATA);
    assign wr_ctrl = wr & (i_apb.paddr == `UART_ADDR_CTRL);
    assign rd_rx   = rd & (i_apb.paddr == `UART_ADDR_RXDATA);

    // launch straight from the access phase so txd drops the next cycle
    assign o_tx_start = wr_tx & ~i_tx_busy;
    assign o_tx_data  = wdata.data.tx_byte;
    assign o_cfg      = cfg_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q <= '0;
        end else if (wr_ctrl) begin
            cfg_q <= '{parity_odd: wdata.ctrl.parity_odd,
                       parity_en:  wdata.ctrl.parity_en};
        end
    end

    // sticky receive flags where a new frame wins over a read in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_valid_q   <= 1'b0;
            parity_err_q <= 1'b0;
            frame_err_q  <= 1'b0;
            overrun_q    <= 1'b0;
        end else begin
            if (rd_rx) begin
                rx_valid_q   <= 1'b0;
                parity_err_q <= 1'b0;
                frame_err_q  <= 1'b0;
                overrun_q    <= 1'b0;
            end
            if (i_rx_done) begin
                rx_valid_q   <= 1'b1;
                parity_err_q <= i_rx_result.parity_err | (parity_err_q & ~rd_rx);
                frame_err_q  <= i_rx_result.frame_err | (frame_err_q & ~rd_rx);
                overrun_q    <= (rx_valid_q & ~rd_rx) | (overrun_q & ~rd_rx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rx_done) begin
            rx_data_q <= i_rx_result.data; // overwrites an unread byte
        end
    end

    assign status = '{overrun:    overrun_q,
                      frame_err:  frame_err_q,
                      parity_err: parity_err_q,
                      rx_valid:   rx_valid_q,
                      tx_busy:    i_tx_busy};

    always_comb begin
        o_apb.prdata  = '0;
        o_apb.pready  = 1'b1;             // zero wait states
        o_apb.pslverr = wr_tx & i_tx_busy; // refuse write while sending
        if (rd) begin
            case (i_apb.paddr)
                `UART_ADDR_RXDATA: o_apb.prdata = {22'd0, frame_err_q, parity_err_q, rx_data_q};
                `UART_ADDR_STATUS: o_apb.prdata = {27'd0, status};
                `UART_ADDR_CTRL:   o_apb.prdata = {30'd0, cfg_q}; // same layout as ctrl view
                default:           o_apb.prdata = '0;
            endcase
        end
    end

    // tx engine goes busy the cycle after a launch
    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        o_tx_start |=> i_tx_busy);

endmodule

/* src/uart_pkg.sv */
`include "uart_macros.svh"

package uart_pkg;

    // frame format, same bit order as the CTRL register
    typedef struct packed {
        logic parity_odd; // odd parity when set, even otherwise
        logic parity_en;  // adds a parity bit before stop
    } frame_cfg_t;

    // result of one received frame
    typedef struct packed {
        logic [`UART_DATA_W-1:0] data;       // lsb first on the line
        logic                    parity_err; // only with parity_en
        logic                    frame_err;  // stop bit sampled low
    } rx_result_t;

    // STATUS read view, tx_busy in bit 0
    typedef struct packed {
        logic overrun;    // frame lost before RXDATA read
        logic frame_err;
        logic parity_err;
        logic rx_valid;   // byte waiting in RXDATA
        logic tx_busy;    // frame on the line
    } status_t;

    // bit phase of a serial engine, shared by tx and rx
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_START  = 3'd1,
        ST_DATA   = 3'd2,
        ST_PARITY = 3'd3,
        ST_STOP   = 3'd4
    } line_state_e;

endpackage

/* src/uart_rx.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_rx (
    input  logic                 clk,
    input  logic                 reset,
    input  uart_pkg::frame_cfg_t i_cfg,
    input  logic                 i_rxd,
    output logic                 o_rx_done,
    output uart_pkg::rx_result_t o_rx_result
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam int IDX_W = $clog2(`UART_DATA_W);
    localparam int HALF  = `UART_CLKS_PER_BIT / 2;

    logic [`UART_SYNC_STAGES-1:0] sync_q;   // async line into clk domain
    logic                         rxd_s;    // synchronised line
    logic                         rxd_prev;
    logic                         start_edge;
    line_state_e                  state;
    logic [CNT_W-1:0]             cnt;
    logic [IDX_W-1:0]             bit_idx;
    logic                         sample;   // mid-bit strobe
    logic [`UART_DATA_W-1:0]      data_q;
    frame_cfg_t                   cfg_q;    // format of the frame in flight
    logic                         perr_q;

    assign rxd_s      = sync_q[`UART_SYNC_STAGES-1];
    assign start_edge = rxd_prev & ~rxd_s;

    // start bit is checked after half a bit, the rest one full bit later
    assign sample = (state == ST_START) ? (cnt == CNT_W'(HALF - 1))
                                        : (cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q   <= '1; // line idles high
            rxd_prev <= 1'b1;
            state    <= ST_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
        end else begin
            sync_q   <= {sync_q[`UART_SYNC_STAGES-2:0], i_rxd};
            rxd_prev <= rxd_s;
            if (state == ST_IDLE) begin
                cnt     <= '0;
                bit_idx <= '0;
                if (start_edge) begin
                    state <= ST_START;
                end
            end else if (!sample) begin
                cnt <= cnt + 1'b1;
            end else begin
                cnt <= '0;
                case (state)
                    ST_START: state <= rxd_s ? ST_IDLE : ST_DATA; // glitch goes back
                    ST_DATA: begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(`UART_DATA_W - 1)) begin
                            state <= cfg_q.parity_en ? ST_PARITY : ST_STOP;
                        end
                    end
                    ST_PARITY: state <= ST_STOP;
                    default:   state <= ST_IDLE; // stop sampled, rearm mid-bit
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start_edge) begin
            cfg_q <= i_cfg;
        end
        if (state == ST_DATA && sample) begin
            data_q <= {rxd_s, data_q[`UART_DATA_W-1:1]}; // lsb arrives first
        end
        if (state == ST_PARITY && sample) begin
            perr_q <= rxd_s ^ (^data_q) ^ cfg_q.parity_odd;
        end
    end

    assign o_rx_done   = (state == ST_STOP) && sample;
    assign o_rx_result = '{data:       data_q,
                           parity_err: cfg_q.parity_en & perr_q,
                           frame_err:  ~rxd_s}; // stop bit low

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        o_rx_done |=> !o_rx_done);

    a_state_range: assert property (@(posedge clk) disable iff (reset)
        state inside {ST_IDLE, ST_START, ST_DATA, ST_PARITY, ST_STOP});

endmodule

/* src/uart_top.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_top (
    input  logic              clk,
    input  logic              reset,
    input  apb_pkg::apb_req_t i_apb,
    output apb_pkg::apb_rsp_t o_apb,
    output logic              o_txd,
    input  logic              i_rxd
);
    import uart_pkg::*;

    frame_cfg_t              cfg;       // to both engines
    logic                    tx_start;
    logic [`UART_DATA_W-1:0] tx_data;
    logic                    tx_busy;
    logic                    rx_done;
    rx_result_t              rx_result;

    uart_ctrl uart_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .i_apb       (i_apb),
        .o_apb       (o_apb),
        .o_cfg       (cfg),
        .o_tx_start  (tx_start),
        .o_tx_data   (tx_data),
        .i_tx_busy   (tx_busy),
        .i_rx_done   (rx_done),
        .i_rx_result (rx_result)
    );

    uart_tx uart_tx_i (
        .clk     (clk),
        .reset   (reset),
        .i_cfg   (cfg),
        .i_start (tx_start),
        .i_data  (tx_data),
        .o_busy  (tx_busy),
        .o_txd   (o_txd)
    );

    uart_rx uart_rx_i (
        .clk         (clk),
        .reset       (reset),
        .i_cfg       (cfg),
        .i_rxd       (i_rxd),
        .o_rx_done   (rx_done),
        .o_rx_result (rx_result)
    );

endmodule

/* src/uart_tx.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tx (
    input  logic                    clk,
    input  logic                    reset,
    input  uart_pkg::frame_cfg_t    i_cfg,
    input  logic                    i_start,
    input  logic [`UART_DATA_W-1:0] i_data,
    output logic                    o_busy,
    output logic                    o_txd
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam int IDX_W = $clog2(`UART_DATA_W);

    line_state_e             state;
    logic [CNT_W-1:0]        cnt;      // clocks inside the current bit
    logic [IDX_W-1:0]        bit_idx;  // data bit on the line
    logic [`UART_DATA_W-1:0] shift_q;  // lsb goes out first
    frame_cfg_t              cfg_q;    // held for the whole frame
    logic                    parity_q;
    logic                    bit_end;

    assign bit_end = (cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
        end else if (state == ST_IDLE) begin
            cnt     <= '0;
            bit_idx <= '0;
            if (i_start) begin
                state <= ST_START;
            end
        end else if (!bit_end) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
            case (state)
                ST_START: state <= ST_DATA;
                ST_DATA: begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == IDX_W'(`UART_DATA_W - 1)) begin
                        state <= cfg_q.parity_en ? ST_PARITY : ST_STOP;
                    end
                end
                ST_PARITY: state <= ST_STOP;
                default:   state <= ST_IDLE; // stop bit done
            endcase
        end
    end

    // payload loads on launch and shifts at each data bit end
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_start) begin
            shift_q  <= i_data;
            cfg_q    <= i_cfg;
            parity_q <= ^i_data ^ i_cfg.parity_odd; // even parity, flipped for odd
        end else if (state == ST_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign o_busy = (state != ST_IDLE);

    always_comb begin
        case (state)
            ST_START:  o_txd = 1'b0;
            ST_DATA:   o_txd = shift_q[0];
            ST_PARITY: o_txd = parity_q;
            default:   o_txd = 1'b1; // idle and stop
        endcase
    end

endmodule

/* verification/uart_tb.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tb;
    import apb_pkg::*;
    import uart_pkg::*;

    localparam int CPB          = `UART_CLKS_PER_BIT;
    localparam int NUM_ROWS     = 9;
    localparam int RESET_CYCLES = 3;
    localparam int ROW_BUDGET   = 11 * CPB + `UART_SYNC_STAGES + 20; // parity frame plus slack
    localparam int CYCLE_LIMIT  = (NUM_ROWS + 2) * ROW_BUDGET + RESET_CYCLES; // busy test is two rows
    localparam int POLL_LIMIT   = 64;
    localparam logic [4:0] M_TX_BUSY  = 5'b0_0001; // STATUS bit positions
    localparam logic [4:0] M_RX_VALID = 5'b0_0010;
    localparam logic [4:0] M_OVERRUN  = 5'b1_0000;

    typedef struct packed {
        logic                    rnd;       // byte comes from $urandom
        logic [`UART_DATA_W-1:0] data;
        logic                    par_en;
        logic                    par_odd;
        logic                    inj_par;   // flip parity bit on the line
        logic                    inj_stop;  // pull stop bit low
        logic                    skip_read; // leave byte unread so the next row overruns
    } row_t;

    row_t                    table_q [NUM_ROWS];
    logic                    clk;
    logic                    reset;
    apb_req_t                apb_req;
    apb_rsp_t                apb_rsp;
    logic                    txd;
    logic                    rxd;
    int                      cycle = 0;
    int                      t0 = 0;          // first cycle of the start bit
    int                      frame_off;
    int                      line_bit;        // bit slot on the line with 0 for start
    int                      stop_slot;
    logic                    frame_on = 1'b0;
    logic [`UART_DATA_W-1:0] mon_data = '0;   // byte of the frame in flight
    logic [`UART_DATA_W-1:0] mon_shift;
    logic                    mon_par_en = 1'b0;
    logic                    mon_par_odd = 1'b0;
    logic                    inj_par;
    logic                    inj_stop;

    uart_top uart_top_i (
        .clk   (clk),
        .reset (reset),
        .i_apb (apb_req),
        .o_apb (apb_rsp),
        .o_txd (txd),
        .i_rxd (rxd)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // loopback with error injection in the parity or stop slot
    assign frame_off = cycle - t0;
    assign line_bit  = frame_off / CPB;
    assign stop_slot = mon_par_en ? 10 : 9;
    assign mon_shift = mon_data >> (line_bit - 1);
    assign rxd = ((inj_par && mon_par_en && line_bit == 9) ||
                  (inj_stop && line_bit == stop_slot)) ? ~txd : txd;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic parity_of(input logic [`UART_DATA_W-1:0] data, input logic odd);
        int ones;
        ones = 0;
        for (int i = 0; i < `UART_DATA_W; i++) begin
            if (data[i]) ones++;
        end
        return ((ones % 2) == 1) ^ odd; // even parity inverted for odd
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            fail_run($sformatf("timeout: run still going after %0d cycles", cycle));
        end
    end

    // frame shape on the tx pin sampled mid-cycle
    always @(negedge clk) begin
        if (frame_on && !reset) begin
            if (frame_off == 0) check("txd start bit", 32'(txd), 32'd0);
            if (line_bit >= 1 && line_bit <= 8 && frame_off % CPB == CPB / 2)
                check("txd data bit", 32'(txd), 32'(mon_shift[0]));
            if (mon_par_en && frame_off == 9 * CPB + CPB / 2)
                check("txd parity bit", 32'(txd), 32'(parity_of(mon_data, mon_par_odd)));
            if (frame_off == stop_slot * CPB + CPB / 2)
                check("txd stop bit", 32'(txd), 32'd1);
        end
    end

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
        apb_req_t req;
        req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req <= req;      // setup phase
        req.penable = 1'b1;
        @(posedge clk);
        apb_req <= req;      // access phase
        @(negedge clk);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check("pready", 32'(apb_rsp.pready), 32'd1);
        @(posedge clk);      // access completes here
        apb_req <= '0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata);
        logic slverr;
        apb_xfer(1'b0, addr, 32'd0, rdata, slverr);
        check("pslverr on read", 32'(slverr), 32'd0);
    endtask

    task automatic set_format(input logic par_en, input logic par_odd);
        logic [31:0] discard;
        logic        slverr;
        apb_xfer(1'b1, `UART_ADDR_CTRL, {30'd0, par_odd, par_en}, discard, slverr);
        check("pslverr on CTRL", 32'(slverr), 32'd0);
        mon_par_en  <= par_en;
        mon_par_odd <= par_odd;
    endtask

    task automatic send_byte(input logic [`UART_DATA_W-1:0] data, input logic refused);
        logic [31:0] discard;
        logic        slverr;
        apb_xfer(1'b1, `UART_ADDR_TXDATA, 32'(data), discard, slverr);
        check("pslverr on TXDATA", 32'(slverr), 32'(refused));
        if (!slverr) begin
            t0       <= cycle + 1; // start bit begins after this edge
            frame_on <= 1'b1;
            mon_data <= data;
        end
    endtask

    task automatic wait_status(input logic [4:0] mask, input logic [4:0] want, output status_t st);
        logic [31:0] rdata;
        int          polls;
        polls = 0;
        do begin
            apb_read(`UART_ADDR_STATUS, rdata);
            st = rdata[4:0];
            polls++;
        end while (((st & mask) != want) && polls < POLL_LIMIT);
        if ((st & mask) != want) begin
            fail_run($sformatf("STATUS polling gave up after %0d reads, mask 0x%0h", polls, mask));
        end
    endtask

    initial begin
        row_t        row;
        status_t     st;
        logic [31:0] rdata;
        logic        prev_skip;
        logic        exp_perr;
        logic        exp_ferr;
        logic        carry_perr;
        logic        carry_ferr;
        reset    = 1'b1;
        apb_req  = '0;
        inj_par  = 1'b0;
        inj_stop = 1'b0;
        void'($urandom(32'h9cb8_127e));
        //            rnd   data   p_en  p_odd inj_p inj_s skip
        table_q[0] = '{1'b0, 8'h55, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0}; // no parity
        table_q[1] = '{1'b0, 8'hA3, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0}; // even
        table_q[2] = '{1'b0, 8'h3C, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0}; // odd
        table_q[3] = '{1'b1, 8'h00, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
        table_q[4] = '{1'b1, 8'h00, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
        table_q[5] = '{1'b0, 8'hC5, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0}; // parity error
        table_q[6] = '{1'b0, 8'h7E, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0}; // framing error
        table_q[7] = '{1'b1, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1}; // left unread
        table_q[8] = '{1'b0, 8'h96, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0}; // overruns row 7
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (table_q[r].rnd) table_q[r].data = 8'($urandom());
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        prev_skip  = 1'b0;
        carry_perr = 1'b0;
        carry_ferr = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            row = table_q[r];
            wait_status(M_TX_BUSY, 5'd0, st);
            set_format(row.par_en, row.par_odd);
            inj_par  <= row.inj_par;
            inj_stop <= row.inj_stop;
            send_byte(row.data, 1'b0);
            exp_perr = row.inj_par | carry_perr; // flags stay until RXDATA is read
            exp_ferr = row.inj_stop | carry_ferr;
            wait_status(prev_skip ? M_OVERRUN : M_RX_VALID, prev_skip ? M_OVERRUN : M_RX_VALID, st);
            if (prev_skip) begin
                check("STATUS.rx_valid", 32'(st.rx_valid), 32'd1); // polled on overrun here
            end else begin
                check("STATUS.overrun", 32'(st.overrun), 32'd0);
            end
            check("STATUS.parity_err", 32'(st.parity_err), 32'(exp_perr));
            check("STATUS.frame_err", 32'(st.frame_err), 32'(exp_ferr));
            if (row.skip_read) begin
                prev_skip  = 1'b1;
                carry_perr = exp_perr;
                carry_ferr = exp_ferr;
            end else begin
                apb_read(`UART_ADDR_RXDATA, rdata);
                check("RXDATA.data", 32'(rdata[7:0]), 32'(row.data));
                check("RXDATA.parity_err", 32'(rdata[8]), 32'(exp_perr));
                check("RXDATA.frame_err", 32'(rdata[9]), 32'(exp_ferr));
                apb_read(`UART_ADDR_STATUS, rdata);
                check("STATUS rx flags after RXDATA read", 32'(rdata[4:1]), 32'd0);
                prev_skip  = 1'b0;
                carry_perr = 1'b0;
                carry_ferr = 1'b0;
            end
        end
        // second write while the first frame is on the line
        wait_status(M_TX_BUSY, 5'd0, st);
        set_format(1'b0, 1'b0);
        inj_par  <= 1'b0;
        inj_stop <= 1'b0;
        send_byte(8'h5A, 1'b0);
        send_byte(8'hA5, 1'b1);
        wait_status(M_RX_VALID, M_RX_VALID, st);
        apb_read(`UART_ADDR_RXDATA, rdata);
        check("RXDATA after refused write", rdata & 32'h3FF, 32'h05A);
        repeat (11 * CPB) @(posedge clk); // room for a frame that must not come
        apb_read(`UART_ADDR_STATUS, rdata);
        check("STATUS.rx_valid after refused write", 32'(rdata[1]), 32'd0);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
